// File: verilog/cpu_pkg.sv
// selector codes 6 to 15 all reach one scratch register and opcodes with bit 7 set take two words
package cpu_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // widths and plain words
   ////////////////////////////////////////////////////////////////////////////
   localparam int word_w = 16;

   typedef logic [word_w-1:0] word_t;     // data and address word
   typedef logic [3:0]        reg_sel_t;  // register selector

   // selector codes
   localparam reg_sel_t sel_zero = 4'd0;  // constant 0
   localparam reg_sel_t sel_one  = 4'd1;  // constant 1
   localparam reg_sel_t sel_r0   = 4'd2;
   localparam reg_sel_t sel_r1   = 4'd3;
   localparam reg_sel_t sel_r2   = 4'd4;
   localparam reg_sel_t sel_r3   = 4'd5;

   ////////////////////////////////////////////////////////////////////////////
   // opcodes and alu ops
   ////////////////////////////////////////////////////////////////////////////
   // msb set means an immediate word follows
   typedef enum logic [7:0] {
      op_nop = 8'h0F,
      op_add = 8'h43,
      op_sub = 8'h44,
      op_and = 8'h47,
      op_or  = 8'h48,
      op_cmp = 8'h49,
      op_li  = 8'hA1   // two words
   } opcode_t;

   typedef enum logic [3:0] {
      alu_and = 4'd0,
      alu_or  = 4'd1,
      alu_add = 4'd5,
      alu_sub = 4'd6,
      alu_slt = 4'd9   // unsigned less than
   } alu_op_t;

   ////////////////////////////////////////////////////////////////////////////
   // stage to stage bundles
   ////////////////////////////////////////////////////////////////////////////
   typedef struct packed {
      opcode_t  opcode;
      reg_sel_t rd;      // first operand and destination
      reg_sel_t rs;      // second operand
   } instr_fields_t;

   // one fetched word, either an instruction or an immediate
   typedef union packed {
      instr_fields_t fields;
      word_t         raw;
   } fetch_word_u;

   typedef struct packed {
      instr_fields_t fields;
      word_t         imm;     // zero for one-word instrs
   } issue_t;

   typedef struct packed {
      alu_op_t  alu_op;
      logic     a_zero;     // operand a forced to 0
      logic     b_imm;      // operand b taken from imm
      logic     reg_write;
      reg_sel_t dest;
   } exec_ctrl_t;

   typedef struct packed {
      reg_sel_t dest;
      word_t    data;
   } wb_t;

endpackage

// File: verilog/fetch_unit.sv
// no stall and no flush here so words already fetched still issue after a jump
`timescale 1ns/1ps

module fetch_unit import cpu_pkg::*; #(
   parameter word_t reset_pc = '0   // first fetch address
) (
   input  logic  clk,
   input  logic  rst_n,
   input  logic  jump_valid,        // plain level, sampled every edge
   input  word_t jump_addr,
   output word_t pc
);

   word_t pc_next;

   ////////////////////////////////////////////////////////////////////////////
   // next pc select
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      if (jump_valid) begin
         pc_next = jump_addr;        // redirect wins
      end else begin
         pc_next = pc + word_t'(1);  // sequential
      end
   end

   // program counter
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         pc <= reset_pc;
      end else begin
         pc <= pc_next;
      end
   end

endmodule

// File: verilog/word_assembler.sv
// instr must arrive one cycle after its pc and any word with opcode bit 7 set eats the next word
`timescale 1ns/1ps

module word_assembler import cpu_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  word_t  instr,
   output logic   issue_valid,   // one pulse per instruction
   output issue_t issue
);

   fetch_word_u   word_in;       // same word seen as fields or raw imm
   logic          two_word;      // opcode msb of a first word
   logic          need_imm;      // waiting for the immediate word
   instr_fields_t held_fields;   // first word parked here meanwhile

   assign word_in  = instr;
   assign two_word = word_in.fields.opcode[7];

   ////////////////////////////////////////////////////////////////////////////
   // sequencing
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         need_imm    <= 1'b0;    // expect a first word
         issue_valid <= 1'b0;
      end else if (need_imm) begin
         need_imm    <= 1'b0;    // imm arrived
         issue_valid <= 1'b1;
      end else begin
         need_imm    <= two_word;
         issue_valid <= !two_word;  // one-word instr goes right away
      end
   end

   // payload only, no reset
   always_ff @(posedge clk) begin
      if (need_imm) begin
         issue.fields <= held_fields;
         issue.imm    <= word_in.raw;   // second word is the immediate
      end else begin
         held_fields <= word_in.fields;
         if (!two_word) begin
            issue.fields <= word_in.fields;
            issue.imm    <= '0;
         end
      end
   end

endmodule

// File: verilog/instr_decoder.sv
// unknown opcodes decode as nop and the output lines up with the registered regfile read
`timescale 1ns/1ps

module instr_decoder import cpu_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       issue_valid,
   input  issue_t     issue,
   output logic       ctrl_valid,   // one cycle after issue_valid
   output exec_ctrl_t ctrl,
   output word_t      imm
);

   exec_ctrl_t ctrl_next;

   ////////////////////////////////////////////////////////////////////////////
   // opcode decode
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      ctrl_next.alu_op    = alu_add;
      ctrl_next.a_zero    = 1'b0;
      ctrl_next.b_imm     = 1'b0;
      ctrl_next.reg_write = 1'b0;
      ctrl_next.dest      = issue.fields.rd;   // rd is always the target
      case (issue.fields.opcode)
         op_add: begin
            ctrl_next.alu_op    = alu_add;
            ctrl_next.reg_write = 1'b1;
         end
         op_sub: begin
            ctrl_next.alu_op    = alu_sub;
            ctrl_next.reg_write = 1'b1;
         end
         op_and: begin
            ctrl_next.alu_op    = alu_and;
            ctrl_next.reg_write = 1'b1;
         end
         op_or: begin
            ctrl_next.alu_op    = alu_or;
            ctrl_next.reg_write = 1'b1;
         end
         op_cmp: begin
            ctrl_next.alu_op    = alu_slt;
            ctrl_next.reg_write = 1'b1;
         end
         op_li: begin
            ctrl_next.alu_op    = alu_add;   // 0 + imm
            ctrl_next.a_zero    = 1'b1;
            ctrl_next.b_imm     = 1'b1;
            ctrl_next.reg_write = 1'b1;
         end
         op_nop: begin
            ctrl_next.reg_write = 1'b0;
         end
         default: begin
            ctrl_next.reg_write = 1'b0;      // treated as nop
         end
      endcase
   end

   // control register
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         ctrl_valid <= 1'b0;
         ctrl       <= '0;
      end else begin
         ctrl_valid <= issue_valid;
         if (issue_valid) begin
            ctrl <= ctrl_next;
         end
      end
   end

   // immediate travels beside the controls
   always_ff @(posedge clk) begin
      if (issue_valid) begin
         imm <= issue.imm;
      end
   end

endmodule

// File: verilog/reg_file.sv
// no bypass so a read in the write cycle sees the old value and codes 6 to 15 share one scratch
`timescale 1ns/1ps

module reg_file import cpu_pkg::*; (
   input  logic   clk,
   input  logic   rst_n,
   input  issue_t issue,
   input  logic   wb_valid,
   input  wb_t    wb,
   input  logic   wb_write,
   output word_t  rd_data,   // registered
   output word_t  rs_data    // registered
);

   word_t gp_regs [4];   // r0..r3
   word_t scratch;       // catches every other code

   // one read port worth of decode
   function automatic word_t read_sel(input reg_sel_t sel);
      case (sel)
         sel_zero: read_sel = '0;
         sel_one:  read_sel = word_t'(1);
         sel_r0:   read_sel = gp_regs[0];
         sel_r1:   read_sel = gp_regs[1];
         sel_r2:   read_sel = gp_regs[2];
         sel_r3:   read_sel = gp_regs[3];
         default:  read_sel = scratch;
      endcase
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // write port
   ////////////////////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         for (int i = 0; i < 4; i++) begin
            gp_regs[i] <= '0;
         end
         scratch <= '0;
      end else if (wb_valid && wb_write) begin
         case (wb.dest)
            sel_r0:  gp_regs[0] <= wb.data;
            sel_r1:  gp_regs[1] <= wb.data;
            sel_r2:  gp_regs[2] <= wb.data;
            sel_r3:  gp_regs[3] <= wb.data;
            default: scratch    <= wb.data;   // also codes 0 and 1
         endcase
      end
   end

   // read ports, every cycle
   always_ff @(posedge clk) begin
      rd_data <= read_sel(issue.fields.rd);
      rs_data <= read_sel(issue.fields.rs);
   end

endmodule

// File: verilog/execute_stage.sv
// single-cycle alu with no flags and a result that appears two cycles after issue
`timescale 1ns/1ps

module execute_stage import cpu_pkg::*; (
   input  logic       clk,
   input  logic       rst_n,
   input  logic       ctrl_valid,
   input  exec_ctrl_t ctrl,
   input  word_t      imm,
   input  word_t      rd_data,
   input  word_t      rs_data,
   output logic       wb_valid,   // only for writing instrs
   output wb_t        wb,
   output logic       wb_write
);

   word_t op_a;
   word_t op_b;
   word_t alu_res;

   ////////////////////////////////////////////////////////////////////////////
   // operand muxes
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      if (ctrl.a_zero) begin
         op_a = '0;          // li path
      end else begin
         op_a = rd_data;
      end
   end

   always_comb begin
      if (ctrl.b_imm) begin
         op_b = imm;
      end else begin
         op_b = rs_data;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // alu
   ////////////////////////////////////////////////////////////////////////////
   always_comb begin
      case (ctrl.alu_op)
         alu_and: alu_res = op_a & op_b;
         alu_or:  alu_res = op_a | op_b;
         alu_add: alu_res = op_a + op_b;   // carry dropped
         alu_sub: alu_res = op_a - op_b;
         alu_slt: begin
            if (op_a < op_b) begin       // unsigned compare
               alu_res = word_t'(1);
            end else begin
               alu_res = '0;
            end
         end
         default: alu_res = '0;
      endcase
   end

   // write-back strobes
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         wb_valid <= 1'b0;
         wb_write <= 1'b0;
      end else begin
         wb_valid <= ctrl_valid && ctrl.reg_write;
         wb_write <= ctrl.reg_write;
      end
   end

   // write-back payload
   always_ff @(posedge clk) begin
      if (ctrl_valid) begin
         wb.dest <= ctrl.dest;
         wb.data <= alu_res;
      end
   end

endmodule

// File: verilog/cpu_core.sv
// no hazard checks so programs keep two words between a write and a read of the same register
`timescale 1ns/1ps

module cpu_core import cpu_pkg::*; #(
   parameter word_t reset_pc = '0
) (
   input  logic  clk,
   input  logic  rst_n,
   input  word_t instr,        // word at last cycle's pc
   input  logic  jump_valid,
   input  word_t jump_addr,
   output word_t pc,
   output logic  wb_valid,
   output wb_t   wb
);

   logic       issue_valid;
   issue_t     issue;
   logic       ctrl_valid;
   exec_ctrl_t ctrl;
   word_t      imm;
   word_t      rd_data;
   word_t      rs_data;
   logic       wb_write;

   ////////////////////////////////////////////////////////////////////////////
   // front end
   ////////////////////////////////////////////////////////////////////////////
   fetch_unit #(
      .reset_pc (reset_pc)
   ) u_fetch (
      .clk        (clk),
      .rst_n      (rst_n),
      .jump_valid (jump_valid),
      .jump_addr  (jump_addr),
      .pc         (pc)
   );

   word_assembler u_asm (
      .clk         (clk),
      .rst_n       (rst_n),
      .instr       (instr),
      .issue_valid (issue_valid),
      .issue       (issue)
   );

   // decode and register read, side by side
   instr_decoder u_dec (
      .clk         (clk),
      .rst_n       (rst_n),
      .issue_valid (issue_valid),
      .issue       (issue),
      .ctrl_valid  (ctrl_valid),
      .ctrl        (ctrl),
      .imm         (imm)
   );

   reg_file u_rf (
      .clk      (clk),
      .rst_n    (rst_n),
      .issue    (issue),
      .wb_valid (wb_valid),
      .wb       (wb),
      .wb_write (wb_write),
      .rd_data  (rd_data),
      .rs_data  (rs_data)
   );

   ////////////////////////////////////////////////////////////////////////////
   // execute and write-back
   ////////////////////////////////////////////////////////////////////////////
   execute_stage u_ex (
      .clk        (clk),
      .rst_n      (rst_n),
      .ctrl_valid (ctrl_valid),
      .ctrl       (ctrl),
      .imm        (imm),
      .rd_data    (rd_data),
      .rs_data    (rs_data),
      .wb_valid   (wb_valid),
      .wb         (wb),
      .wb_write   (wb_write)
   );

endmodule

// File: verif/cpu_tb.sv
// reads verif/cpu_patterns.txt relative to the run directory and trusts programs to keep spacing
`timescale 1ns/1ps

module cpu_tb import cpu_pkg::*; ();

   localparam word_t nop_word = {op_nop, 8'h00};   // nop, zero fields
   localparam word_t start_pc = 16'h0000;          // reset_pc handed to the core

   logic  clk = 1'b0;
   logic  rst_n;
   word_t instr;
   logic  jump_valid;
   word_t jump_addr;
   word_t pc;
   logic  wb_valid;
   wb_t   wb;

   word_t mem [word_t];          // sparse program image
   wb_t   w_recs [$];            // W records, program order
   wb_t   model_q [$];           // write-backs the model still owes
   word_t model_regs [5];        // r0..r3 then scratch
   logic  model_wait;            // first half of a two-word instr seen
   word_t model_first;

   word_t jump_at;               // start of the nop stretch
   word_t jump_to;
   word_t end_addr;              // one past the last P address
   word_t exp_pc;
   word_t addr_q;                // pc of the cycle before
   logic  load_ok;
   int    w_idx = 0;
   int    wb_count = 0;
   int    pc_errs = 0;
   int    wb_errs = 0;
   int    other_errs = 0;
   int unsigned cycle_cnt = 0;
   int unsigned cycle_limit = 32'd100000;   // tightened after the load

   cpu_core #(
      .reset_pc (start_pc)
   ) uut (
      .clk        (clk),
      .rst_n      (rst_n),
      .instr      (instr),
      .jump_valid (jump_valid),
      .jump_addr  (jump_addr),
      .pc         (pc),
      .wb_valid   (wb_valid),
      .wb         (wb)
   );

   always #2 clk = ~clk;   // 4 ns

   // run limit
   always @(posedge clk) begin
      cycle_cnt = cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         $display("timeout, run stopped after %0d cycles", cycle_cnt);
         $display("Finished with errors");
         $finish;
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // instruction memory and reference model
   ////////////////////////////////////////////////////////////////////////////
   function automatic word_t fetch_word(input word_t addr);
      if (mem.exists(addr)) begin
         return mem[addr];
      end
      return nop_word;   // unlisted address
   endfunction

   // r0..r3 sit in slots 0..3, all other codes share slot 4
   function automatic int reg_slot(input reg_sel_t sel);
      if (sel >= sel_r0 && sel <= sel_r3) begin
         return int'(sel - sel_r0);
      end
      return 4;
   endfunction

   function automatic word_t read_model_reg(input reg_sel_t sel);
      if (sel == sel_zero) begin
         return '0;
      end
      if (sel == sel_one) begin
         return 16'd1;
      end
      return model_regs[reg_slot(sel)];
   endfunction

   // one complete instruction at architectural level
   task automatic exec_instr(input word_t w, input word_t imm);
      reg_sel_t rd;
      word_t    a;
      word_t    b;
      word_t    res;
      logic     writes;
      wb_t      rec;
      rd     = w[7:4];
      a      = read_model_reg(rd);
      b      = read_model_reg(w[3:0]);
      writes = 1'b1;
      case (w[15:8])
         op_add: res = a + b;
         op_sub: res = a - b;
         op_and: res = a & b;
         op_or:  res = a | b;
         op_cmp: res = (a < b) ? 16'd1 : 16'd0;   // unsigned
         op_li:  res = imm;
         default: begin
            res    = '0;
            writes = 1'b0;   // nop or unknown
         end
      endcase
      if (writes) begin
         model_regs[reg_slot(rd)] = res;
         rec.dest = rd;
         rec.data = res;
         model_q.push_back(rec);
      end
   endtask

   // every word the core consumes passes through here
   task automatic model_word(input word_t w);
      if (model_wait) begin
         model_wait = 1'b0;
         exec_instr(model_first, w);   // w is the immediate
      end else if (w[15]) begin
         model_wait  = 1'b1;
         model_first = w;
      end else begin
         exec_instr(w, '0);
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // pattern file
   ////////////////////////////////////////////////////////////////////////////
   task automatic load_patterns();
      int         fd;
      int         n;
      string      line;
      logic [7:0] tag;
      word_t      a;
      word_t      b;
      wb_t        rec;
      logic       have_jump;
      have_jump = 1'b0;
      end_addr  = '0;
      load_ok   = 1'b0;
      fd = $fopen("verif/cpu_patterns.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("cannot open the pattern file verif/cpu_patterns.txt");
      end else begin
         while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line.getc(0) != "#") begin
               n = $sscanf(line, "%c %h %h", tag, a, b);
               if (n != 3) begin
                  other_errs++;
                  $display("pattern line not understood: %s", line);
               end else if (tag == "P") begin
                  mem[a] = b;
                  if (a >= end_addr) begin
                     end_addr = a + 16'd1;
                  end
               end else if (tag == "J") begin
                  jump_at   = a;
                  jump_to   = b;
                  have_jump = 1'b1;
               end else if (tag == "W") begin
                  rec.dest = a[3:0];
                  rec.data = b;
                  w_recs.push_back(rec);
               end else begin
                  other_errs++;
                  $display("pattern line has an unknown tag: %s", line);
               end
            end
         end
         $fclose(fd);
         if (!have_jump || mem.size() == 0) begin
            other_errs++;
            $display("pattern file lacks program words or the jump record");
         end else begin
            load_ok = 1'b1;
         end
      end
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // per-cycle drive and checks
   ////////////////////////////////////////////////////////////////////////////
   task automatic check_wb();
      wb_t exp;
      if (wb_valid) begin
         wb_count++;
         if (model_q.size() == 0) begin
            other_errs++;
            $display("ERR %0t: write-back to %h with no instruction behind it", $time, wb.dest);
         end else begin
            exp = model_q.pop_front();
            if (wb !== exp) begin
               wb_errs++;
               $display("ERR %0t: write-back %h=%h, model wants %h=%h",
                        $time, wb.dest, wb.data, exp.dest, exp.data);
            end
         end
         if (w_idx < w_recs.size()) begin
            if (wb !== w_recs[w_idx]) begin
               wb_errs++;
               $display("ERR %0t: write-back %0d is %h=%h, W record says %h=%h",
                        $time, w_idx, wb.dest, wb.data, w_recs[w_idx].dest, w_recs[w_idx].data);
            end
            w_idx++;
         end
      end
   endtask

   task automatic step_cycle();
      @(posedge clk);
      #1;                              // outputs settled, inputs move now
      if (pc !== exp_pc) begin
         pc_errs++;
         $display("ERR %0t: pc is %h, expected %h", $time, pc, exp_pc);
      end
      check_wb();
      instr  = fetch_word(addr_q);     // one cycle of read latency
      model_word(instr);
      addr_q = pc;
      exp_pc = exp_pc + 16'd1;         // sequential from the last expected pc
   endtask

   task automatic run_program();
      word_t jump_pc;
      jump_pc = jump_at + word_t'($urandom % 8);   // random spot in the nop stretch
      while (pc !== jump_pc) begin
         step_cycle();
      end
      jump_valid = 1'b1;
      jump_addr  = jump_to;
      exp_pc     = jump_to;
      step_cycle();
      jump_valid = 1'b0;               // single-cycle strobe
      while (pc !== end_addr + 16'd6) begin
         step_cycle();                 // let the pipe drain
      end
   endtask

   initial begin
      void'($urandom(32'h80e4_b430));
      rst_n      = 1'b0;
      instr      = nop_word;
      jump_valid = 1'b0;
      jump_addr  = '0;
      model_wait = 1'b0;
      for (int i = 0; i < 5; i++) begin
         model_regs[i] = '0;
      end
      load_patterns();
      if (load_ok) begin
         cycle_limit = 2 * 32'(end_addr) + 32'd100;
         repeat (5) begin
            @(posedge clk);
            #1;
            if (pc !== start_pc || wb_valid !== 1'b0) begin
               pc_errs++;
               $display("ERR %0t: during reset pc=%h wb_valid=%b", $time, pc, wb_valid);
            end
         end
         rst_n  = 1'b1;
         model_word(instr);            // held nop goes in first
         addr_q = pc;
         exp_pc = start_pc + 16'd1;
         run_program();
         if (model_q.size() != 0) begin
            other_errs++;
            $display("%0d write-backs from the model never appeared", model_q.size());
         end
         if (wb_count != w_recs.size()) begin
            other_errs++;
            $display("saw %0d write-backs but the file lists %0d", wb_count, w_recs.size());
         end
      end
      $display("errors: pc %0d, write-back %0d, other %0d", pc_errs, wb_errs, other_errs);
      if (pc_errs + wb_errs + other_errs == 0) begin
         $display("Finished with no errors");
      end else begin
         $display("Finished with errors");
      end
      $finish;
   end

endmodule

// File: list.f
verilog/cpu_pkg.sv
verilog/fetch_unit.sv
verilog/word_assembler.sv
verilog/instr_decoder.sv
verilog/reg_file.sv
verilog/execute_stage.sv
verilog/cpu_core.sv
verif/cpu_tb.sv

// File: run_sim.sh
#!/bin/sh
# builds the cpu testbench with verilator and runs it from the project root
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --top-module cpu_tb -f list.f

# the pattern file path inside the testbench is relative to this directory
./obj_dir/Vcpu_tb > sim.log 2>&1
cat sim.log

if grep -q "Finished with errors" sim.log; then
   echo "simulation failed, see sim.log"
   exit 1
fi
echo "simulation passed"

// File: verif/cpu_patterns.txt
# columns are a tag then two hex fields
# P addr word   J jump start and target   W dest and expected value
P 0000 A120
P 0001 1234
P 0002 A130
P 0003 0F0F
P 0004 A190
P 0005 FFF0
P 0008 4323
P 0009 443C
P 000A 4851
P 000B 472C
P 000C 4930
P 000D 495C
P 0030 7F23
P 0031 4425
J 0010 0030
W 2 1234
W 3 0F0F
W 9 FFF0
W 2 2143
W 3 0F1F
W 5 0001
W 2 2140
W 3 0000
W 5 0001
W 2 213F
